// ==== lsuPkg.sv ====
`default_nettype none

package lsuPkg;

    localparam int idWidth  = 6;
    localparam int regWidth = 6;

    // Unmapped segments folded onto physical space
    localparam logic [31:0] kseg0Base = 32'h8000_0000;
    localparam logic [31:0] kseg1Base = 32'hA000_0000;
    localparam logic [31:0] ksegSize  = 32'h2000_0000;

    localparam int ramWords   = 1024;
    localparam int ramIdxBits = $clog2(ramWords);

    typedef enum logic [3:0] {
        opNone,
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opSb,
        opSh,
        opSw
    } memOp;

    typedef enum logic [1:0] {
        clsNone,
        clsLoad,
        clsStore
    } opClass;

    // Issued micro-op
    typedef struct packed {
        memOp                op;
        logic [idWidth-1:0]  id;
        logic [regWidth-1:0] dst;
        logic [15:0]         imm;
    } lsuUop;

    // Address side of the captured op
    typedef struct packed {
        opClass      cls;
        logic [31:0] addr;
        logic [1:0]  offset;
        logic [31:0] storeData;
    } lsuAddrInfo;

    typedef struct packed {
        logic [regWidth-1:0] dst;
        logic [31:0]         data;
    } wbInfo;

endpackage

`default_nettype wire

// ==== memBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// Request channel for reads and writes
interface memReqIf;
    logic        valid;
    logic        ready;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strobe;

    modport lsu (output valid, write, addr, data, strobe, input ready);
    modport mem (input valid, write, addr, data, strobe, output ready);
endinterface

// Response channel carrying read data only
interface memRespIf;
    logic        valid;
    logic        ready;
    logic [31:0] data;

    modport lsu (input valid, data, output ready);
    modport mem (output valid, data, input ready);
endinterface

`default_nettype wire

// ==== lsuIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuIssue import lsuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        take,
    input  logic        uopValid,
    input  lsuUop       uop,
    input  logic [31:0] rsBase,
    input  logic [31:0] rsData,
    output lsuUop       curUop,
    output lsuAddrInfo  addrInfo
);

    logic [31:0] effAddr;
    logic [31:0] physAddr;
    opClass      newClass;

    function automatic opClass classOf(input memOp op);
        case (op)
            opLb, opLbu, opLh, opLhu, opLw: classOf = clsLoad;
            opSb, opSh, opSw:               classOf = clsStore;
            default:                        classOf = clsNone;
        endcase
    endfunction

    // kseg0 and kseg1 alias the same low 512 MB
    function automatic logic [31:0] foldAddr(input logic [31:0] va);
        if (va >= kseg0Base && va < kseg0Base + ksegSize) begin
            foldAddr = va - kseg0Base;
        end else if (va >= kseg1Base && va < kseg1Base + ksegSize) begin
            foldAddr = va - kseg1Base;
        end else begin
            foldAddr = va;
        end
    endfunction

    assign effAddr  = rsBase + {{16{uop.imm[15]}}, uop.imm};
    assign physAddr = foldAddr(effAddr);
    assign newClass = uopValid ? classOf(uop.op) : clsNone;

    //////////////////////////////
    // Issue register
    //////////////////////////////

    // A take without uopValid empties the register
    always_ff @(posedge clk) begin
        if (rst) begin
            curUop.op    <= opNone;
            addrInfo.cls <= clsNone;
        end else if (take) begin
            curUop.op    <= uopValid ? uop.op : opNone;
            addrInfo.cls <= newClass;
            if (uopValid) begin
                curUop.id          <= uop.id;
                curUop.dst         <= uop.dst;
                curUop.imm         <= uop.imm;
                addrInfo.addr      <= {physAddr[31:2], 2'b00};
                addrInfo.offset    <= physAddr[1:0];
                addrInfo.storeData <= rsData;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsuControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuControl import lsuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       fireStore,
    input  lsuUop      curUop,
    input  lsuAddrInfo addrInfo,
    output logic       take,
    output logic       busy,
    output logic       loadDone,
    output logic       storeFinish,
    memReqIf.lsu       req,
    memRespIf.lsu      resp
);

    typedef enum logic [2:0] {
        sIdle,
        sLoadReq,
        sLoadResp,
        sStoreHold,
        sStoreFire,
        sRecover,
        sReset
    } lsuState;

    lsuState     state;
    lsuState     nextState;
    logic        hasLoad;
    logic        hasStore;
    logic        loadPhase;
    logic        opDone;
    logic [3:0]  storeStrobe;
    logic [31:0] storeLanes;

    assign hasLoad  = addrInfo.cls == clsLoad;
    assign hasStore = addrInfo.cls == clsStore;

    // A fresh load already requests from the idle cycle
    assign loadPhase = (state == sIdle && hasLoad) || state == sLoadReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sReset;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            sIdle, sLoadReq: begin
                if (loadPhase) begin
                    // An accepted request must still be drained
                    if (flush) begin
                        nextState = req.ready ? sRecover : sReset;
                    end else if (req.ready) begin
                        nextState = sLoadResp;
                    end else begin
                        nextState = sLoadReq;
                    end
                end else if (hasStore) begin
                    if (flush) begin
                        nextState = sReset;
                    end else if (fireStore) begin
                        nextState = sStoreFire;
                    end else begin
                        nextState = sStoreHold;
                    end
                end
            end
            sLoadResp: begin
                if (resp.valid) begin
                    nextState = flush ? sReset : sIdle;
                end else if (flush) begin
                    nextState = sRecover;
                end
            end
            sStoreHold: begin
                if (flush) begin
                    nextState = sReset;
                end else if (fireStore) begin
                    nextState = sStoreFire;
                end
            end
            sStoreFire: begin
                // A committed store ignores flush
                if (req.ready) begin
                    nextState = sIdle;
                end
            end
            sRecover: begin
                if (resp.valid) begin
                    nextState = sIdle;
                end
            end
            sReset: begin
                if (!flush) begin
                    nextState = sIdle;
                end
            end
            default: begin
                nextState = sReset;
            end
        endcase
    end

    // Lane strobes and replicated store data
    always_comb begin
        case (curUop.op)
            opSb: begin
                storeStrobe = 4'b0001 << addrInfo.offset;
                storeLanes  = {4{addrInfo.storeData[7:0]}};
            end
            opSh: begin
                storeStrobe = addrInfo.offset[1] ? 4'b1100 : 4'b0011;
                storeLanes  = {2{addrInfo.storeData[15:0]}};
            end
            default: begin
                storeStrobe = 4'b1111;
                storeLanes  = addrInfo.storeData;
            end
        endcase
    end

    assign req.valid  = loadPhase || state == sStoreFire;
    assign req.write  = state == sStoreFire;
    assign req.addr   = addrInfo.addr;
    assign req.data   = storeLanes;
    assign req.strobe = (state == sStoreFire) ? storeStrobe : 4'b0000;
    assign resp.ready = state == sLoadResp || state == sRecover;

    assign loadDone    = state == sLoadResp && resp.valid && !flush;
    assign storeFinish = state == sIdle && hasStore && !flush;

    assign opDone = loadDone || (state == sStoreFire && req.ready)
                    || (state == sRecover && resp.valid);

    // The issue register loads when empty, after reset recovery, or as an op ends
    assign take = (state == sIdle && addrInfo.cls == clsNone)
                  || (state == sReset && !flush) || opDone;

    assign busy = (state == sIdle) ? addrInfo.cls != clsNone : state != sReset;

endmodule

`default_nettype wire

// ==== loadAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadAlign import lsuPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               loadDone,
    input  logic               storeFinish,
    input  lsuUop              curUop,
    input  logic [1:0]         offset,
    input  logic [31:0]        respData,
    output logic               wbValid,
    output wbInfo              wb,
    output logic               finishValid,
    output logic [idWidth-1:0] finishId
);

    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [31:0] loadData;

    assign byteLane = respData[{offset, 3'b000} +: 8];
    assign halfLane = offset[1] ? respData[31:16] : respData[15:0];

    always_comb begin
        case (curUop.op)
            opLb:    loadData = {{24{byteLane[7]}}, byteLane};
            opLbu:   loadData = {24'b0, byteLane};
            opLh:    loadData = {{16{halfLane[15]}}, halfLane};
            opLhu:   loadData = {16'b0, halfLane};
            default: loadData = respData;
        endcase
    end

    //////////////////////////////
    // Report registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid     <= 1'b0;
            finishValid <= 1'b0;
        end else begin
            wbValid     <= loadDone;
            finishValid <= loadDone || storeFinish;
        end
    end

    always_ff @(posedge clk) begin
        if (loadDone) begin
            wb.dst  <= curUop.dst;
            wb.data <= loadData;
        end
        if (loadDone || storeFinish) begin
            finishId <= curUop.id;
        end
    end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataRam import lsuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    memReqIf.mem  req,
    memRespIf.mem resp
);

    logic [31:0]           mem [ramWords];
    logic [31:0]           readData;
    logic                  pending;
    logic                  reqFire;
    logic [ramIdxBits-1:0] wordIdx;

    assign wordIdx = req.addr[ramIdxBits+1:2];

    // One outstanding read at most
    assign req.ready  = !pending && !stall;
    assign reqFire    = req.valid && req.ready;
    assign resp.valid = pending && !stall;
    assign resp.data  = readData;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (reqFire && !req.write) begin
            pending <= 1'b1;
        end else if (resp.valid && resp.ready) begin
            pending <= 1'b0;
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reqFire) begin
            if (req.write) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (req.strobe[lane]) begin
                        mem[wordIdx][lane*8 +: 8] <= req.data[lane*8 +: 8];
                    end
                end
            end else begin
                // Held until the response is taken
                readData <= mem[wordIdx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop import lsuPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                fireStore,
    input  logic                memStall,
    input  logic                uopValid,
    input  memOp                uopOp,
    input  logic [idWidth-1:0]  uopId,
    input  logic [regWidth-1:0] uopDst,
    input  logic [15:0]         uopImm,
    input  logic [31:0]         rsBase,
    input  logic [31:0]         rsData,
    output logic                busy,
    output logic                wbValid,
    output logic                finishValid,
    output logic [regWidth-1:0] wbDst,
    output logic [idWidth-1:0]  finishId,
    output logic [31:0]         wbData
);

    lsuUop      uop;
    lsuUop      curUop;
    lsuAddrInfo addrInfo;
    wbInfo      wb;
    logic       take;
    logic       loadDone;
    logic       storeFinish;

    memReqIf  memReq ();
    memRespIf memResp ();

    assign uop.op  = uopOp;
    assign uop.id  = uopId;
    assign uop.dst = uopDst;
    assign uop.imm = uopImm;

    assign wbDst  = wb.dst;
    assign wbData = wb.data;

    lsuIssue uIssue (
        .clk(clk), .rst(rst), .take(take), .uopValid(uopValid), .uop(uop),
        .rsBase(rsBase), .rsData(rsData), .curUop(curUop), .addrInfo(addrInfo)
    );

    lsuControl uControl (
        .clk(clk), .rst(rst), .flush(flush), .fireStore(fireStore),
        .curUop(curUop), .addrInfo(addrInfo), .take(take), .busy(busy),
        .loadDone(loadDone), .storeFinish(storeFinish), .req(memReq), .resp(memResp)
    );

    loadAlign uAlign (
        .clk(clk), .rst(rst), .loadDone(loadDone), .storeFinish(storeFinish),
        .curUop(curUop), .offset(addrInfo.offset), .respData(memResp.data),
        .wbValid(wbValid), .wb(wb), .finishValid(finishValid), .finishId(finishId)
    );

    dataRam uRam (
        .clk(clk), .rst(rst), .stall(memStall), .req(memReq), .resp(memResp)
    );

endmodule

`default_nettype wire

// ==== tbLsuModel.svh ====
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// Expected RAM contents, one entry per word
logic [31:0] image [ramWords];

// kseg0 and kseg1 both alias the low 512 MB
function automatic logic [31:0] foldRef(input logic [31:0] va);
    if (va[31:30] == 2'b10) begin
        return {3'b000, va[28:0]};
    end
    return va;
endfunction

// Store size picks how many lanes change, the offset picks where
function automatic logic [31:0] mergeRef(input logic [31:0] old, input logic [31:0] data,
                                         input memOp op, input logic [1:0] off);
    logic [31:0] merged;
    int          size;
    int          first;
    merged = old;
    size   = (op == opSb) ? 1 : (op == opSh) ? 2 : 4;
    first  = int'(off) / size * size;
    for (int b = 0; b < size; b++) begin
        merged[(first+b)*8 +: 8] = data[b*8 +: 8];
    end
    return merged;
endfunction

// Lane shifted down to bit 0, then extended
function automatic logic [31:0] loadRef(input logic [31:0] word, input memOp op,
                                        input logic [1:0] off);
    logic [31:0] lane;
    lane = word >> (8 * int'(off));
    case (op)
        opLb:    return {{24{lane[7]}}, lane[7:0]};
        opLbu:   return {24'h0, lane[7:0]};
        opLh:    return {{16{lane[15]}}, lane[15:0]};
        opLhu:   return {16'h0, lane[15:0]};
        default: return word;
    endcase
endfunction

`endif

// ==== tbLsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbLsu import lsuPkg::*; ();

    // Op counts of each test set the cycle budget
    localparam int wordOps     = 2 * 16;
    localparam int subwordOps  = 4 * 20;
    localparam int foldOps     = 3 * 4;
    localparam int flushOps    = 7;
    localparam int worstCycles = 24;
    localparam int cycleLimit  = 8 * (wordOps + subwordOps + foldOps + flushOps) * worstCycles;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                fireStore;
    logic                memStall = 1'b0;
    logic                uopValid;
    memOp                uopOp;
    logic [idWidth-1:0]  uopId;
    logic [regWidth-1:0] uopDst;
    logic [15:0]         uopImm;
    logic [31:0]         rsBase;
    logic [31:0]         rsData;
    logic                busy;
    logic                wbValid;
    logic                finishValid;
    logic [regWidth-1:0] wbDst;
    logic [idWidth-1:0]  finishId;
    logic [31:0]         wbData;

    wbInfo               wbExp [$];
    logic [idWidth-1:0]  idExp [$];
    wbInfo               wbAct;
    logic [31:0]         stored [$];
    logic [idWidth-1:0]  nextId = '0;
    logic                stallRandom = 1'b1;
    logic                stallForce = 1'b0;
    logic [31:0]         stallDraw;
    int                  cycles = 0;
    string               testName = "reset";

    `include "tbLsuModel.svh"

    lsuTop i_dut (
        .clk(clk), .rst(rst), .flush(flush), .fireStore(fireStore), .memStall(memStall),
        .uopValid(uopValid), .uopOp(uopOp), .uopId(uopId), .uopDst(uopDst), .uopImm(uopImm),
        .rsBase(rsBase), .rsData(rsData), .busy(busy), .wbValid(wbValid),
        .finishValid(finishValid), .wbDst(wbDst), .finishId(finishId), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWb(input string name, input wbInfo expWb, input wbInfo actWb);
        if (actWb !== expWb) begin
            failRun($sformatf("[ERROR] %s: expected dst %0d data %h, actual dst %0d data %h",
                              name, expWb.dst, expWb.data, actWb.dst, actWb.data));
        end
    endtask

    task automatic checkId(input string name, input logic [idWidth-1:0] expId,
                           input logic [idWidth-1:0] actId);
        if (actId !== expId) begin
            failRun($sformatf("[ERROR] %s: expected finish id %0d, actual finish id %0d",
                              name, expId, actId));
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic waitIdle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // Base plus a small signed offset lands on va
    task automatic issueOp(input memOp op, input logic [31:0] va, input logic [31:0] data,
                           input logic [regWidth-1:0] dst);
        logic [31:0] r;
        logic [15:0] imm;
        r   = $urandom();
        imm = {{10{r[5]}}, r[5:0]};
        waitIdle();
        @(posedge clk);
        uopValid <= 1'b1;
        uopOp    <= op;
        uopId    <= nextId;
        uopDst   <= dst;
        uopImm   <= imm;
        rsBase   <= va - {{16{imm[15]}}, imm};
        rsData   <= data;
        @(posedge clk);
        uopValid <= 1'b0;
        nextId = nextId + idWidth'(1);
    endtask

    task automatic doLoad(input memOp op, input logic [31:0] va);
        logic [31:0] pa;
        logic [31:0] r;
        wbInfo       expWb;
        pa         = foldRef(va);
        r          = $urandom();
        expWb.dst  = r[regWidth-1:0];
        expWb.data = loadRef(image[pa[ramIdxBits+1:2]], op, pa[1:0]);
        wbExp.push_back(expWb);
        idExp.push_back(nextId);
        issueOp(op, va, 32'h0, expWb.dst);
        waitIdle();
        @(posedge clk);
        if (wbExp.size() != 0) begin
            failRun("load went idle without a write-back");
        end
    endtask

    // Finish must be seen before the store is fired
    task automatic doStore(input memOp op, input logic [31:0] va, input logic [31:0] data);
        logic [31:0] pa;
        logic [31:0] r;
        pa = foldRef(va);
        r  = $urandom();
        idExp.push_back(nextId);
        issueOp(op, va, data, r[regWidth-1:0]);
        while (idExp.size() != 0) begin
            @(posedge clk);
        end
        repeat (r[10:8]) @(posedge clk);
        fireStore <= 1'b1;
        @(posedge clk);
        fireStore <= 1'b0;
        image[pa[ramIdxBits+1:2]] = mergeRef(image[pa[ramIdxBits+1:2]], data, op, pa[1:0]);
        waitIdle();
    endtask

    task automatic flushStore(input logic [31:0] va, input logic [31:0] data);
        idExp.push_back(nextId);
        issueOp(opSb, va, data, '0);
        while (idExp.size() != 0) begin
            @(posedge clk);
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        waitIdle();
    endtask

    // stalled keeps the request from being accepted
    task automatic flushLoad(input logic [31:0] va, input logic stalled, input int delay);
        stallRandom = 1'b0;
        stallForce  = stalled;
        issueOp(opLw, va, 32'h0, '0);
        repeat (delay) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        waitIdle();
        stallRandom = 1'b1;
    endtask

    //////////////////////////////
    // Checking and limits
    //////////////////////////////

    always @(negedge clk) begin
        if (wbValid) begin
            wbAct.dst  = wbDst;
            wbAct.data = wbData;
            if (wbExp.size() == 0) begin
                failRun("write-back pulse without an outstanding load");
            end else if (!finishValid) begin
                failRun("write-back pulse without its finish report");
            end else begin
                checkWb(testName, wbExp.pop_front(), wbAct);
            end
        end
        if (finishValid) begin
            if (idExp.size() == 0) begin
                failRun("finish pulse without an outstanding op");
            end else begin
                checkId(testName, idExp.pop_front(), finishId);
            end
        end
    end

    // One stall cycle in four
    always @(posedge clk) begin
        stallDraw = $urandom();
        memStall <= stallRandom ? (stallDraw[1:0] == 2'b00) : stallForce;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            failRun("timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        void'($urandom(82829));
        rst       = 1'b1;
        flush     = 1'b0;
        fireStore = 1'b0;
        uopValid  = 1'b0;
        uopOp     = opNone;
        uopId     = '0;
        uopDst    = '0;
        uopImm    = '0;
        rsBase    = '0;
        rsData    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        testName = "word";
        for (int i = 0; i < 16; i++) begin
            r = $urandom();
            a = {20'h0, r[11:2], 2'b00};
            stored.push_back(a);
            doStore(opSw, a, $urandom());
        end
        foreach (stored[i]) begin
            doLoad(opLw, stored[i]);
        end

        testName = "subword";
        for (int i = 0; i < 4; i++) begin
            r = $urandom();
            a = {20'h0, r[11:2], 2'b00};
            doStore(opSw, a, $urandom());
            for (int off = 0; off < 4; off++) begin
                doStore(opSb, a + off, $urandom());
                doLoad(opLb, a + off);
                doLoad(opLbu, a + off);
            end
            for (int off = 0; off < 4; off += 2) begin
                doStore(opSh, a + off, $urandom());
                doLoad(opLh, a + off);
                doLoad(opLhu, a + off);
            end
            doLoad(opLw, a);
        end

        // Same word seen through kseg1, kseg0 and physical space
        testName = "fold";
        for (int i = 0; i < 3; i++) begin
            r = $urandom();
            a = {20'h0, r[11:2], 2'b00};
            doStore(opSw, kseg1Base + a, $urandom());
            doLoad(opLw, kseg0Base + a);
            doLoad(opLw, a);
            doLoad(opLw, kseg1Base + a);
        end

        testName = "flush";
        r = $urandom();
        a = {20'h0, r[11:2], 2'b00};
        doStore(opSw, a, $urandom());
        // Flushed byte differs from the stored one
        flushStore(a + 1, {24'h0, ~image[a[ramIdxBits+1:2]][15:8]});
        doLoad(opLw, a);
        flushLoad(a, 1'b1, 0);
        flushLoad(a, 1'b0, 0);
        flushLoad(a, 1'b0, 1);
        doLoad(opLw, a);

        repeat (2) @(posedge clk);
        if (wbExp.size() == 0 && idExp.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failRun("an expected write-back or finish pulse never arrived");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
lsuPkg.sv
memBus.sv
lsuIssue.sv
lsuControl.sv
loadAlign.sv
dataRam.sv
lsuTop.sv
tbLsu.sv

// ==== Makefile ====
# Verilator simulation of the load/store unit

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, pass when the log holds the pass message"
	@echo "  clean  remove the build directory and the log"

obj_dir/VtbLsu: compile.f $(wildcard *.sv) tbLsuModel.svh
	verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tbLsu -o VtbLsu

test: obj_dir/VtbLsu
	./obj_dir/VtbLsu > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
